// ==== common/hazard_pkg.sv ====
package hazard_pkg;

    // basic widths
    localparam int INST_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int OPC_W      = 7;
    localparam int FWD_SEL_W  = 2;

    // stages after ID: slot 0 is EX, slot 1 MEM, slot 2 WB
    localparam int PIPE_DEPTH = 3;

    // field positions inside an RV64I word
    localparam int RD_LSB  = 7;
    localparam int RS1_LSB = 15;
    localparam int RS2_LSB = 20;

    typedef logic [INST_W-1:0]     inst_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [OPC_W-1:0]      opcode_t;
    typedef logic [FWD_SEL_W-1:0]  fwd_sel_t;   // slot index + 1, 0 = register file

    localparam reg_addr_t REG_X0   = '0;
    localparam fwd_sel_t  FWD_NONE = '0;

    // major opcodes
    localparam opcode_t OPC_LOAD      = 7'b0000011;
    localparam opcode_t OPC_STORE     = 7'b0100011;
    localparam opcode_t OPC_BRANCH    = 7'b1100011;
    localparam opcode_t OPC_OP        = 7'b0110011;
    localparam opcode_t OPC_OP_IMM    = 7'b0010011;
    localparam opcode_t OPC_OP_32     = 7'b0111011;
    localparam opcode_t OPC_OP_IMM_32 = 7'b0011011;
    localparam opcode_t OPC_LUI       = 7'b0110111;
    localparam opcode_t OPC_AUIPC     = 7'b0010111;
    localparam opcode_t OPC_JAL       = 7'b1101111;
    localparam opcode_t OPC_JALR      = 7'b1100111;

    // operands the ID instruction actually reads
    typedef struct packed {
        reg_addr_t rs1;
        reg_addr_t rs2;
        logic      use_rs1;
        logic      use_rs2;
    } src_req_t;

    // one in-flight register write
    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        logic      is_load;   // data only ready after MEM
    } dest_t;

    // per-slot compare result for the merge
    typedef struct packed {
        logic hit_rs1;
        logic hit_rs2;
        logic is_load;
    } slot_hit_t;

endpackage

// ==== src/id_fields_decode.sv ====
`timescale 1ns/1ps

module id_fields_decode import hazard_pkg::*; (
    input  inst_t    id_inst,
    input  logic     id_valid,
    input  logic     stall,      // instruction held at ID this cycle
    output src_req_t src_req,
    output dest_t    dest_in
);

    opcode_t   opcode;
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    logic      reads_rs1;
    logic      reads_rs2;
    logic      writes_rd;
    logic      load_op;

    assign opcode = id_inst[OPC_W-1:0];
    assign rd     = id_inst[RD_LSB +: REG_ADDR_W];
    assign rs1    = id_inst[RS1_LSB +: REG_ADDR_W];
    assign rs2    = id_inst[RS2_LSB +: REG_ADDR_W];

    // read/write class per format
    always_comb begin
        reads_rs1 = 1'b0;
        reads_rs2 = 1'b0;
        writes_rd = 1'b0;
        load_op   = 1'b0;
        case (opcode)
            OPC_LOAD: begin
                reads_rs1 = 1'b1;
                writes_rd = 1'b1;
                load_op   = 1'b1;
            end
            OPC_STORE, OPC_BRANCH: begin
                reads_rs1 = 1'b1;   // no destination
                reads_rs2 = 1'b1;
            end
            OPC_OP, OPC_OP_32: begin
                reads_rs1 = 1'b1;
                reads_rs2 = 1'b1;
                writes_rd = 1'b1;
            end
            OPC_OP_IMM, OPC_OP_IMM_32, OPC_JALR: begin
                reads_rs1 = 1'b1;   // immediate takes the rs2 field
                writes_rd = 1'b1;
            end
            OPC_LUI, OPC_AUIPC, OPC_JAL: begin
                writes_rd = 1'b1;
            end
            default: begin
                // unknown opcode touches nothing
                reads_rs1 = 1'b0;
                reads_rs2 = 1'b0;
            end
        endcase
    end

    // x0 reads are constant zero, never forwarded
    assign src_req.rs1     = rs1;
    assign src_req.rs2     = rs2;
    assign src_req.use_rs1 = reads_rs1 && (rs1 != REG_X0);
    assign src_req.use_rs2 = reads_rs2 && (rs2 != REG_X0);

    // a bubble or a stalled cycle sends nothing down the chain,
    // the held word is sent again once stall drops
    assign dest_in.valid   = writes_rd && (rd != REG_X0) && id_valid && !stall;
    assign dest_in.rd      = rd;
    assign dest_in.is_load = load_op;

endmodule

// ==== src/pending_slot.sv ====
`timescale 1ns/1ps

module pending_slot import hazard_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  dest_t     dest_in,    // from the stage before
    input  src_req_t  src_req,    // operands of the ID instruction
    output dest_t     dest_out,
    output slot_hit_t hit
);

    dest_t held;

    // true when this stage will write the requested source
    function automatic logic src_match(
        input dest_t     d,
        input reg_addr_t src,
        input logic      use_src
    );
        logic same_reg;
        same_reg = (d.rd == src);
        return d.valid && use_src && same_reg;
    endfunction

    // advances every edge, the chain itself never holds
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            held <= '0;
        end else begin
            held <= dest_in;
        end
    end

    assign dest_out = held;

    // compare against the registered record only
    always_comb begin
        hit.hit_rs1 = src_match(held, src_req.rs1, src_req.use_rs1);
        hit.hit_rs2 = src_match(held, src_req.rs2, src_req.use_rs2);
        hit.is_load = held.is_load;   // only meaningful next to a hit
    end

endmodule

// ==== src/fwd_stall_merge.sv ====
`timescale 1ns/1ps

module fwd_stall_merge import hazard_pkg::*; (
    input  logic      id_valid,
    input  slot_hit_t hits [PIPE_DEPTH],   // index 0 is EX
    output logic      stall,
    output fwd_sel_t  fwd_rs1,
    output fwd_sel_t  fwd_rs2
);

    logic [PIPE_DEPTH-1:0] rs1_hits;
    logic [PIPE_DEPTH-1:0] rs2_hits;
    logic [PIPE_DEPTH-1:0] load_hits;
    fwd_sel_t              sel_rs1;
    fwd_sel_t              sel_rs2;
    logic                  load_use;

    // lowest slot index holds the newest value
    function automatic fwd_sel_t nearest_hit(input logic [PIPE_DEPTH-1:0] hv);
        fwd_sel_t sel;
        sel = FWD_NONE;
        for (int k = PIPE_DEPTH - 1; k >= 0; k--) begin
            if (hv[k]) begin
                sel = fwd_sel_t'(k + 1);   // overwritten by nearer stages
            end
        end
        return sel;
    endfunction

    // flatten the slot records into per-field vectors
    always_comb begin
        for (int k = 0; k < PIPE_DEPTH; k++) begin
            rs1_hits[k]  = hits[k].hit_rs1;
            rs2_hits[k]  = hits[k].hit_rs2;
            load_hits[k] = hits[k].is_load;
        end
    end

    assign sel_rs1 = nearest_hit(rs1_hits);
    assign sel_rs2 = nearest_hit(rs2_hits);

    // a slot 0 hit is always the winner, so a load there has no data yet
    assign load_use = (rs1_hits[0] || rs2_hits[0]) && load_hits[0];
    assign stall    = id_valid && load_use;

    // selects are meaningless for a held instruction
    always_comb begin
        if (stall) begin
            fwd_rs1 = FWD_NONE;
            fwd_rs2 = FWD_NONE;
        end else begin
            fwd_rs1 = sel_rs1;
            fwd_rs2 = sel_rs2;
        end
    end

endmodule

// ==== src/hazard_top.sv ====
`timescale 1ns/1ps

module hazard_top import hazard_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     id_valid,
    input  inst_t    id_inst,
    output logic     stall,
    output fwd_sel_t fwd_rs1,
    output fwd_sel_t fwd_rs2
);

    src_req_t  src_req;
    dest_t     dest_chain [PIPE_DEPTH+1];   // entry 0 from decode, last one retires
    slot_hit_t slot_hits  [PIPE_DEPTH];

    id_fields_decode u_decode (
        .id_inst  (id_inst),
        .id_valid (id_valid),
        .stall    (stall),
        .src_req  (src_req),
        .dest_in  (dest_chain[0])
    );

    // one slot per stage after ID
    for (genvar k = 0; k < PIPE_DEPTH; k++) begin : g_slot
        pending_slot u_slot (
            .clk      (clk),
            .rst_n    (rst_n),
            .dest_in  (dest_chain[k]),
            .src_req  (src_req),
            .dest_out (dest_chain[k+1]),
            .hit      (slot_hits[k])
        );
    end

    fwd_stall_merge u_merge (
        .id_valid (id_valid),
        .hits     (slot_hits),
        .stall    (stall),
        .fwd_rs1  (fwd_rs1),
        .fwd_rs2  (fwd_rs2)
    );

endmodule

// ==== verif/hazard_asserts.sv ====
`timescale 1ns/1ps

module hazard_asserts import hazard_pkg::*; (
    input logic     clk,
    input logic     rst_n,
    input logic     id_valid,
    input inst_t    id_inst,
    input logic     stall,
    input fwd_sel_t fwd_rs1,
    input fwd_sel_t fwd_rs2
);

    // only a real instruction can be held
    a_stall_needs_valid: assert property (
        @(posedge clk) disable iff (!rst_n) stall |-> id_valid
    ) else $error("stall raised for a bubble");

    a_stall_no_fwd: assert property (
        @(posedge clk) disable iff (!rst_n)
        stall |-> (fwd_rs1 == FWD_NONE && fwd_rs2 == FWD_NONE)
    ) else $error("forward select active during stall");

    // load moves to MEM after one cycle
    a_single_stall: assert property (
        @(posedge clk) disable iff (!rst_n)
        (stall && $past(stall)) |-> (id_inst != $past(id_inst))
    ) else $error("same word stalled two cycles in a row");

endmodule

bind hazard_top hazard_asserts u_asserts (
    .clk      (clk),
    .rst_n    (rst_n),
    .id_valid (id_valid),
    .id_inst  (id_inst),
    .stall    (stall),
    .fwd_rs1  (fwd_rs1),
    .fwd_rs2  (fwd_rs2)
);

// ==== verif/hazard_tb.sv ====
`timescale 1ns/1ps

module hazard_tb import hazard_pkg::*; ();

    localparam fwd_sel_t SEL_NONE = 2'd0;
    localparam fwd_sel_t SEL_EX   = 2'd1;
    localparam fwd_sel_t SEL_MEM  = 2'd2;
    localparam fwd_sel_t SEL_WB   = 2'd3;

    // expected selects apply once stall has dropped
    typedef struct packed {
        logic     valid;
        inst_t    inst;
        logic     stall;
        fwd_sel_t f1;
        fwd_sel_t f2;
    } row_t;

    logic     clk = 1'b0;
    logic     rst_n;
    logic     id_valid;
    inst_t    id_inst;
    logic     stall;
    fwd_sel_t fwd_rs1;
    fwd_sel_t fwd_rs2;

    row_t      table_q [$];

    // reference chain with EX at index 0
    logic      mv  [PIPE_DEPTH];
    reg_addr_t mrd [PIPE_DEPTH];
    logic      mld [PIPE_DEPTH];

    hazard_top u_dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .id_valid (id_valid),
        .id_inst  (id_inst),
        .stall    (stall),
        .fwd_rs1  (fwd_rs1),
        .fwd_rs2  (fwd_rs2)
    );

    always #50 clk = ~clk;   // 100 ns period

    function automatic inst_t enc(input opcode_t opc, input reg_addr_t rd,
                                  input reg_addr_t rs1, input reg_addr_t rs2);
        return {7'b0000000, rs2, rs1, 3'b000, rd, opc};
    endfunction

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic opcode_t pick_opcode(input int idx);
        case (idx)
            0:       return OPC_LOAD;
            1:       return OPC_STORE;
            2:       return OPC_BRANCH;
            3:       return OPC_OP;
            4:       return OPC_OP_IMM;
            5:       return OPC_OP_32;
            6:       return OPC_OP_IMM_32;
            7:       return OPC_LUI;
            8:       return OPC_AUIPC;
            9:       return OPC_JAL;
            10:      return OPC_JALR;
            default: return 7'b1111111;   // not a real opcode
        endcase
    endfunction

    // registers only from x0..x3 so collisions are common
    function automatic inst_t random_word(input logic [31:0] r);
        opcode_t opc;
        opc = pick_opcode(int'(r % 32'd12));
        return {r[31:25], 3'b000, r[13:12], 3'b000, r[11:10], r[16:14], 3'b000, r[9:8], opc};
    endfunction

    // which fields an instruction format reads and writes
    task automatic classify(input inst_t w, output logic r1, output logic r2,
                            output logic wr, output logic ld);
        opcode_t opc;
        opc = w[6:0];
        r1 = opc inside {OPC_LOAD, OPC_STORE, OPC_BRANCH, OPC_OP, OPC_OP_IMM,
                         OPC_OP_32, OPC_OP_IMM_32, OPC_JALR};
        r2 = opc inside {OPC_STORE, OPC_BRANCH, OPC_OP, OPC_OP_32};
        wr = opc inside {OPC_LOAD, OPC_OP, OPC_OP_IMM, OPC_OP_32, OPC_OP_IMM_32,
                         OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR};
        ld = (opc == OPC_LOAD);
    endtask

    function automatic fwd_sel_t ref_sel(input reg_addr_t src, input logic use_it);
        fwd_sel_t sel;
        sel = SEL_NONE;
        if (use_it) begin
            for (int k = 0; k < PIPE_DEPTH; k++) begin
                if (sel == SEL_NONE && mv[k] && mrd[k] == src) begin
                    sel = fwd_sel_t'(k + 1);
                end
            end
        end
        return sel;
    endfunction

    task automatic ref_eval(input logic v, input inst_t w, output logic st,
                            output fwd_sel_t f1, output fwd_sel_t f2);
        logic     r1, r2, wr, ld;
        fwd_sel_t s1, s2;
        classify(w, r1, r2, wr, ld);
        s1 = ref_sel(w[19:15], r1 && (w[19:15] != 5'd0));
        s2 = ref_sel(w[24:20], r2 && (w[24:20] != 5'd0));
        st = v && mld[0] && (s1 == SEL_EX || s2 == SEL_EX);   // load still in EX
        f1 = st ? SEL_NONE : s1;
        f2 = st ? SEL_NONE : s2;
    endtask

    always @(posedge clk or negedge rst_n) begin : model_step
        logic     st, r1, r2, wr, ld;
        fwd_sel_t f1, f2;
        if (!rst_n) begin
            for (int k = 0; k < PIPE_DEPTH; k++) begin
                mv[k]  = 1'b0;
                mrd[k] = 5'd0;
                mld[k] = 1'b0;
            end
        end else begin
            ref_eval(id_valid, id_inst, st, f1, f2);
            classify(id_inst, r1, r2, wr, ld);
            for (int k = PIPE_DEPTH - 1; k > 0; k--) begin
                mv[k]  = mv[k-1];
                mrd[k] = mrd[k-1];
                mld[k] = mld[k-1];
            end
            mv[0]  = id_valid && wr && (id_inst[11:7] != 5'd0) && !st;
            mrd[0] = id_inst[11:7];
            mld[0] = ld;
        end
    end

    task automatic check_stall(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("ERR %0t: %s stall is %b, expected %b", $time, what, got, exp);
            $display("Done: errors found");
            $fatal(1);
        end
    endtask

    task automatic check_fwd(input fwd_sel_t got, input fwd_sel_t exp, input string what);
        if (got !== exp) begin
            $display("ERR %0t: %s select is %0d, expected %0d", $time, what, got, exp);
            $display("Done: errors found");
            $fatal(1);
        end
    endtask

    task automatic drive_inputs(input logic v, input inst_t w);
        @(posedge clk);
        #1;
        id_valid = v;
        id_inst  = w;
    endtask

    // word stays put while the load moves on to MEM
    task automatic wait_stall_clear(input int limit);
        int   held;
        logic cleared;
        held    = 1;
        cleared = 1'b0;
        for (int n = 0; n < limit && !cleared; n++) begin
            @(posedge clk);
            @(negedge clk);
            if (stall) held++;
            else cleared = 1'b1;
        end
        if (!cleared) begin
            $display("stall never cleared while the instruction was held at ID");
            $display("Done: errors found");
            $fatal(1);
        end else if (held != 1) begin
            $display("ERR %0t: stall held for %0d cycles, expected 1", $time, held);
            $display("Done: errors found");
            $fatal(1);
        end
    endtask

    task automatic add_row(input logic v, input inst_t w, input logic st,
                           input fwd_sel_t f1, input fwd_sel_t f2);
        table_q.push_back('{v, w, st, f1, f2});
    endtask

    task automatic add_bubbles(input int n);
        for (int k = 0; k < n; k++) add_row(1'b0, '0, 1'b0, SEL_NONE, SEL_NONE);
    endtask

    task automatic build_table();
        add_bubbles(3);
        // a bubble carrying a word that writes x1 leaves nothing behind
        add_row(1'b0, enc(OPC_OP, 5'd1, 5'd1, 5'd1), 1'b0, SEL_NONE, SEL_NONE);
        // forwarding distance 1, 2, 3
        add_row(1'b1, enc(OPC_OP, 5'd1, 5'd1, 5'd3), 1'b0, SEL_NONE, SEL_NONE);
        add_row(1'b1, enc(OPC_OP, 5'd4, 5'd1, 5'd0), 1'b0, SEL_EX, SEL_NONE);
        add_row(1'b1, enc(OPC_OP, 5'd5, 5'd0, 5'd1), 1'b0, SEL_NONE, SEL_MEM);
        add_row(1'b1, enc(OPC_OP, 5'd6, 5'd1, 5'd4), 1'b0, SEL_WB, SEL_MEM);
        add_bubbles(3);
        // load-use on rs1, then on rs2
        add_row(1'b1, enc(OPC_LOAD, 5'd1, 5'd2, 5'd0), 1'b0, SEL_NONE, SEL_NONE);
        add_row(1'b1, enc(OPC_OP, 5'd3, 5'd1, 5'd2), 1'b1, SEL_MEM, SEL_NONE);
        add_row(1'b1, enc(OPC_OP, 5'd4, 5'd3, 5'd1), 1'b0, SEL_EX, SEL_WB);
        add_bubbles(3);
        add_row(1'b1, enc(OPC_LOAD, 5'd2, 5'd0, 5'd0), 1'b0, SEL_NONE, SEL_NONE);
        add_row(1'b1, enc(OPC_OP, 5'd5, 5'd0, 5'd2), 1'b1, SEL_NONE, SEL_MEM);
        add_bubbles(3);
        // same rd in flight twice
        add_row(1'b1, enc(OPC_OP, 5'd1, 5'd2, 5'd3), 1'b0, SEL_NONE, SEL_NONE);
        add_row(1'b1, enc(OPC_OP_IMM, 5'd1, 5'd1, 5'd1), 1'b0, SEL_EX, SEL_NONE);
        add_row(1'b1, enc(OPC_OP, 5'd2, 5'd1, 5'd1), 1'b0, SEL_EX, SEL_EX);
        add_row(1'b1, enc(OPC_LOAD, 5'd1, 5'd2, 5'd0), 1'b0, SEL_EX, SEL_NONE);
        add_row(1'b1, enc(OPC_OP, 5'd1, 5'd0, 5'd0), 1'b0, SEL_NONE, SEL_NONE);
        add_row(1'b1, enc(OPC_OP, 5'd5, 5'd1, 5'd1), 1'b0, SEL_EX, SEL_EX);
        add_bubbles(3);
        add_row(1'b1, enc(OPC_OP, 5'd1, 5'd2, 5'd3), 1'b0, SEL_NONE, SEL_NONE);
        add_row(1'b1, enc(OPC_LOAD, 5'd1, 5'd3, 5'd0), 1'b0, SEL_NONE, SEL_NONE);
        add_row(1'b1, enc(OPC_OP, 5'd6, 5'd1, 5'd0), 1'b1, SEL_MEM, SEL_NONE);
        add_bubbles(3);
        // cases that must not forward
        add_row(1'b1, enc(OPC_OP, 5'd1, 5'd2, 5'd3), 1'b0, SEL_NONE, SEL_NONE);
        add_row(1'b1, enc(OPC_OP, 5'd2, 5'd0, 5'd0), 1'b0, SEL_NONE, SEL_NONE);
        add_row(1'b1, enc(OPC_LUI, 5'd3, 5'd1, 5'd2), 1'b0, SEL_NONE, SEL_NONE);
        add_row(1'b1, enc(OPC_JAL, 5'd4, 5'd3, 5'd2), 1'b0, SEL_NONE, SEL_NONE);
        add_row(1'b1, enc(OPC_STORE, 5'd5, 5'd0, 5'd0), 1'b0, SEL_NONE, SEL_NONE);
        add_row(1'b1, enc(OPC_BRANCH, 5'd6, 5'd0, 5'd0), 1'b0, SEL_NONE, SEL_NONE);
        add_row(1'b1, enc(OPC_OP, 5'd7, 5'd5, 5'd6), 1'b0, SEL_NONE, SEL_NONE);
        add_row(1'b1, enc(OPC_OP_IMM, 5'd9, 5'd7, 5'd7), 1'b0, SEL_EX, SEL_NONE);
        add_row(1'b1, enc(7'b1111111, 5'd10, 5'd9, 5'd9), 1'b0, SEL_NONE, SEL_NONE);
        add_row(1'b1, enc(OPC_OP, 5'd11, 5'd10, 5'd10), 1'b0, SEL_NONE, SEL_NONE);
        add_bubbles(3);
        // load-use pattern on a bubble shows selects but never stalls
        add_row(1'b1, enc(OPC_LOAD, 5'd1, 5'd0, 5'd0), 1'b0, SEL_NONE, SEL_NONE);
        add_row(1'b0, enc(OPC_OP, 5'd2, 5'd1, 5'd1), 1'b0, SEL_EX, SEL_EX);
        add_bubbles(3);
    endtask

    initial begin
        row_t        row;
        logic [31:0] rng;
        inst_t       word;
        logic        valid;
        logic        e_st;
        fwd_sel_t    e1, e2;

        // a live word during reset must not reach the chain
        rst_n    = 1'b0;
        id_valid = 1'b1;
        id_inst  = enc(OPC_OP, 5'd1, 5'd1, 5'd1);
        rng      = 32'd66160;
        build_table();
        repeat (8) @(posedge clk);
        #1 rst_n = 1'b1;

        @(negedge clk);
        check_stall(stall, 1'b0, "after reset");
        check_fwd(fwd_rs1, SEL_NONE, "after reset rs1");
        check_fwd(fwd_rs2, SEL_NONE, "after reset rs2");

        foreach (table_q[i]) begin
            row = table_q[i];
            drive_inputs(row.valid, row.inst);
            @(negedge clk);
            check_stall(stall, row.stall, $sformatf("row %0d", i));
            if (row.stall) begin
                check_fwd(fwd_rs1, SEL_NONE, $sformatf("row %0d stalled rs1", i));
                check_fwd(fwd_rs2, SEL_NONE, $sformatf("row %0d stalled rs2", i));
                wait_stall_clear(4);
            end
            check_fwd(fwd_rs1, row.f1, $sformatf("row %0d rs1", i));
            check_fwd(fwd_rs2, row.f2, $sformatf("row %0d rs2", i));
        end

        for (int n = 0; n < 200; n++) begin
            rng   = xorshift(rng);
            word  = random_word(rng);
            valid = (rng[23:20] != 4'd0);
            drive_inputs(valid, word);
            @(negedge clk);
            ref_eval(valid, word, e_st, e1, e2);
            check_stall(stall, e_st, $sformatf("random %0d", n));
            check_fwd(fwd_rs1, e1, $sformatf("random %0d rs1", n));
            check_fwd(fwd_rs2, e2, $sformatf("random %0d rs2", n));
            if (e_st) begin
                wait_stall_clear(4);
                ref_eval(valid, word, e_st, e1, e2);
                check_stall(stall, e_st, $sformatf("random %0d released", n));
                check_fwd(fwd_rs1, e1, $sformatf("random %0d released rs1", n));
                check_fwd(fwd_rs2, e2, $sformatf("random %0d released rs2", n));
            end
        end

        drive_inputs(1'b0, '0);
        @(negedge clk);
        $display("Done: no errors");
        $finish;
    end

endmodule

// ==== vlog.f ====
common/hazard_pkg.sv
src/id_fields_decode.sv
src/pending_slot.sv
src/fwd_stall_merge.sv
src/hazard_top.sv
verif/hazard_asserts.sv
verif/hazard_tb.sv

// ==== Makefile ====
TOP := hazard_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f vlog.f --top-module $(TOP) -Mdir obj_dir

run: build
	@out="$$(./obj_dir/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Done: no errors"

lint:
	verilator --lint-only --timing -f vlog.f --top-module $(TOP)

clean:
	rm -rf obj_dir
